/* common/trace_pkg.sv */
// trace package
// isa encoding, per-stage event records and the retired-instruction trace record

package trace_pkg;

    // tag width, eight tags for at most five instructions in flight
    localparam int tag_w = 3;

    // opcode lives in instr[15:12]
    typedef enum logic [3:0] {
        op_nop   = 4'h0,
        op_add   = 4'h1,
        op_sub   = 4'h2,
        op_and   = 4'h3,
        op_or    = 4'h4,
        op_xor   = 4'h5,
        op_addi  = 4'h6,
        op_load  = 4'h7,
        op_store = 4'h8
    } opcode_e;

    // imm[2:0] is rs2 for register ops, signed offset otherwise
    // store takes its data from the rd field
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic [5:0] imm;
    } instr_t;

    ////////////////////////////////////////////////////////////
    // stage events, valid for one cycle as the stage advances
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [7:0]       pc;
        logic [15:0]      word;
    } fetch_event_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [15:0]      result;
    } exec_event_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic             is_store;
        logic [3:0]       addr;
        logic [15:0]      sdata;
    } mem_event_t;

    // also the layout of the mem/wb pipeline register
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic             we;
        logic [2:0]       rd;
        logic [15:0]      wdata;
    } wb_event_t;

    // one record per retired instruction
    typedef struct packed {
        logic [15:0] seq;
        logic [7:0]  pc;
        logic [15:0] word;
        logic [15:0] result;
        logic        is_store;
        logic [3:0]  addr;
        logic        we;
        logic [2:0]  rd;
        logic [15:0] wdata;
    } trace_rec_t;

endpackage

/* core/alu.sv */
// execute-stage alu
// arithmetic, logic and effective address for load and store

module alu (
    input  trace_pkg::opcode_e op,
    input  logic [15:0]        a,
    input  logic [15:0]        b,
    output logic [15:0]        y
);

    import trace_pkg::*;

    always_comb begin
        case (op)
            // addi, load and store all add rs1 and the immediate
            op_add, op_addi, op_load, op_store: begin
                y = a + b;
            end
            op_sub: begin
                y = a - b;
            end
            op_and: begin
                y = a & b;
            end
            op_or: begin
                y = a | b;
            end
            op_xor: begin
                y = a ^ b;
            end
            // nop and undefined codes
            default: begin
                y = 16'h0000;
            end
        endcase
    end

endmodule

/* core/regfile.sv */
// register file, eight 16-bit registers, r0 reads as zero
// two async read ports with write-through, one sync write port

module regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  rs1,
    input  logic [2:0]  rs2,
    output logic [15:0] rd1,
    output logic [15:0] rd2,
    input  logic        we,
    input  logic [2:0]  wa,
    input  logic [15:0] wd
);

    logic [15:0] regs [8];
    logic        wr_live;

    // writes to r0 dropped, so r0 stays at its reset value
    assign wr_live = we && (wa != 3'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wa] <= wd;
        end
    end

    // same-cycle write-back bypass
    assign rd1 = (wr_live && wa == rs1) ? wd : regs[rs1];
    assign rd2 = (wr_live && wa == rs2) ? wd : regs[rs2];

endmodule

/* core/hazard_unit.sv */
// hazard unit
// forwarding select per operand and load-use stall detection

module hazard_unit (
    input  logic [2:0] id_rs1,
    input  logic [2:0] id_rs2,
    input  logic [2:0] ex_rd,
    input  logic [2:0] mem_rd,
    input  logic       ex_we,
    input  logic       mem_we,
    input  logic       ex_is_load,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b,
    output logic       load_stall
);

    logic ex_live;
    logic mem_live;

    // only producers that really write a nonzero register count
    assign ex_live  = ex_we && (ex_rd != 3'd0);
    assign mem_live = mem_we && (mem_rd != 3'd0);

    // resolved in decode, used one cycle later in execute
    // 1: producer now in execute, read from memory stage
    // 2: producer now in memory, read from write-back stage
    // execute-stage producer is the newer one and wins
    always_comb begin
        fwd_a = 2'd0;
        if (ex_live && ex_rd == id_rs1) begin
            fwd_a = 2'd1;
        end else if (mem_live && mem_rd == id_rs1) begin
            fwd_a = 2'd2;
        end
        fwd_b = 2'd0;
        if (ex_live && ex_rd == id_rs2) begin
            fwd_b = 2'd1;
        end else if (mem_live && mem_rd == id_rs2) begin
            fwd_b = 2'd2;
        end
    end

    // load data is only ready after the memory stage
    assign load_stall = ex_is_load && ex_live && (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

/* core/pipe_core.sv */
// five-stage in-order core, fetch decode execute memory write-back
// streamed instructions, 16-word data memory, per-stage trace events

module pipe_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [15:0]             instr,
    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  logic                    freeze,
    output trace_pkg::fetch_event_t fetch_ev,
    output trace_pkg::exec_event_t  exec_ev,
    output trace_pkg::mem_event_t   mem_ev,
    output trace_pkg::wb_event_t    wb_ev
);

    import trace_pkg::*;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        instr_t           word;
    } if_id_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        opcode_e          op;
        logic [2:0]       rd;
        logic             we;
        logic [15:0]      imm;
        logic [15:0]      a;
        logic [15:0]      b;
        logic [1:0]       fwd_a;
        logic [1:0]       fwd_b;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        opcode_e          op;
        logic [2:0]       rd;
        logic             we;
        logic [15:0]      result;
        logic [15:0]      sdata;
    } ex_mem_t;

    if_id_t           if_id;
    id_ex_t           id_ex;
    ex_mem_t          ex_mem;
    wb_event_t        mem_wb;
    logic [7:0]       pc;
    logic [tag_w-1:0] tag_next;
    logic [15:0]      dmem [16];

    logic             accept;
    logic             load_stall;
    logic [2:0]       src1;
    logic [2:0]       src2;
    logic             dec_we;
    logic [15:0]      rd1;
    logic [15:0]      rd2;
    logic [1:0]       fwd_a;
    logic [1:0]       fwd_b;
    logic             rf_we;
    logic [15:0]      op_a;
    logic [15:0]      op_b;
    logic [15:0]      alu_b;
    logic [15:0]      alu_y;
    logic             is_load;
    logic             is_store;
    logic [3:0]       mem_addr;
    logic [15:0]      mem_rdata;

    ////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////

    assign instr_ready = !rst && !freeze && !load_stall;
    assign accept      = instr_valid && instr_ready;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    // source registers, zero when unused so no false hazards
    always_comb begin
        src1   = 3'd0;
        src2   = 3'd0;
        dec_we = 1'b0;
        if (if_id.valid) begin
            case (if_id.word.opcode)
                op_add, op_sub, op_and, op_or, op_xor: begin
                    src1   = if_id.word.rs1;
                    src2   = if_id.word.imm[2:0];
                    dec_we = 1'b1;
                end
                op_addi, op_load: begin
                    src1   = if_id.word.rs1;
                    dec_we = 1'b1;
                end
                // store data comes from rd
                op_store: begin
                    src1 = if_id.word.rs1;
                    src2 = if_id.word.rd;
                end
                default: begin
                    dec_we = 1'b0;
                end
            endcase
        end
    end

    assign rf_we = mem_wb.valid && mem_wb.we && !freeze;

    regfile u_regfile (
        .clk (clk),
        .rst (rst),
        .rs1 (src1),
        .rs2 (src2),
        .rd1 (rd1),
        .rd2 (rd2),
        .we  (rf_we),
        .wa  (mem_wb.rd),
        .wd  (mem_wb.wdata)
    );

    hazard_unit u_hazard (
        .id_rs1     (src1),
        .id_rs2     (src2),
        .ex_rd      (id_ex.rd),
        .mem_rd     (ex_mem.rd),
        .ex_we      (id_ex.valid && id_ex.we),
        .mem_we     (ex_mem.valid && ex_mem.we),
        .ex_is_load (id_ex.op == op_load),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .load_stall (load_stall)
    );

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.fwd_a)
            2'd1:    op_a = ex_mem.result;
            2'd2:    op_a = mem_wb.wdata;
            default: op_a = id_ex.a;
        endcase
        case (id_ex.fwd_b)
            2'd1:    op_b = ex_mem.result;
            2'd2:    op_b = mem_wb.wdata;
            default: op_b = id_ex.b;
        endcase
    end

    // immediate forms take the sign-extended offset as b
    assign alu_b = (id_ex.op == op_addi || id_ex.op == op_load || id_ex.op == op_store) ?
                   id_ex.imm : op_b;

    alu u_alu (
        .op (id_ex.op),
        .a  (op_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    ////////////////////////////////////////////////////////////
    // memory
    ////////////////////////////////////////////////////////////

    assign is_load   = ex_mem.op == op_load;
    assign is_store  = ex_mem.op == op_store;
    assign mem_addr  = ex_mem.result[3:0];
    assign mem_rdata = dmem[mem_addr];

    // pipeline advance, everything holds on freeze
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            tag_next <= '0;
            if_id    <= '0;
            id_ex    <= '0;
            ex_mem   <= '0;
            mem_wb   <= '0;
            for (int i = 0; i < 16; i++) begin
                dmem[i] <= '0;
            end
        end else if (!freeze) begin
            if (accept) begin
                pc       <= pc + 8'd1;
                tag_next <= tag_next + 1'b1;
            end
            // load-use stall holds fetch/decode
            if (!load_stall) begin
                if_id.valid <= accept;
                if_id.tag   <= tag_next;
                if_id.word  <= instr_t'(instr);
            end
            // bubble into execute on stall
            id_ex.valid <= if_id.valid && !load_stall;
            id_ex.tag   <= if_id.tag;
            id_ex.op    <= if_id.word.opcode;
            id_ex.rd    <= if_id.word.rd;
            id_ex.we    <= dec_we;
            id_ex.imm   <= {{10{if_id.word.imm[5]}}, if_id.word.imm};
            id_ex.a     <= rd1;
            id_ex.b     <= rd2;
            id_ex.fwd_a <= fwd_a;
            id_ex.fwd_b <= fwd_b;
            ex_mem.valid  <= id_ex.valid;
            ex_mem.tag    <= id_ex.tag;
            ex_mem.op     <= id_ex.op;
            ex_mem.rd     <= id_ex.rd;
            ex_mem.we     <= id_ex.we;
            ex_mem.result <= alu_y;
            ex_mem.sdata  <= op_b;
            mem_wb.valid <= ex_mem.valid;
            mem_wb.tag   <= ex_mem.tag;
            mem_wb.we    <= ex_mem.we;
            mem_wb.rd    <= ex_mem.rd;
            mem_wb.wdata <= is_load ? mem_rdata : ex_mem.result;
            if (ex_mem.valid && is_store) begin
                dmem[mem_addr] <= ex_mem.sdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // trace events
    ////////////////////////////////////////////////////////////

    always_comb begin
        fetch_ev.valid = accept;
        fetch_ev.tag   = tag_next;
        fetch_ev.pc    = pc;
        fetch_ev.word  = instr;

        exec_ev.valid  = id_ex.valid && !freeze;
        exec_ev.tag    = id_ex.tag;
        exec_ev.result = alu_y;

        // address only meaningful for memory ops
        mem_ev.valid    = ex_mem.valid && !freeze;
        mem_ev.tag      = ex_mem.tag;
        mem_ev.is_store = is_store;
        mem_ev.addr     = (is_load || is_store) ? mem_addr : 4'h0;
        mem_ev.sdata    = is_store ? ex_mem.sdata : 16'h0000;

        wb_ev       = mem_wb;
        wb_ev.valid = mem_wb.valid && !freeze;
    end

endmodule

/* trace/trace_unit.sv */
// retirement trace unit
// gathers stage events per tag, emits one record per retired instruction

module trace_unit #(
    parameter int trace_depth = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  trace_pkg::fetch_event_t fetch_ev,
    input  trace_pkg::exec_event_t  exec_ev,
    input  trace_pkg::mem_event_t   mem_ev,
    input  trace_pkg::wb_event_t    wb_ev,
    output logic                    freeze,
    output trace_pkg::trace_rec_t   trace,
    output logic                    trace_valid,
    input  logic                    trace_ready
);

    import trace_pkg::*;

    localparam int ptr_w = $clog2(trace_depth);

    // what earlier stages reported for one tag
    typedef struct packed {
        logic [7:0]  pc;
        logic [15:0] word;
        logic [15:0] result;
        logic        is_store;
        logic [3:0]  addr;
        logic [15:0] sdata;
    } entry_t;

    entry_t         rec_table [2**tag_w];
    trace_rec_t     queue [trace_depth];
    logic [ptr_w:0] wr_ptr;
    logic [ptr_w:0] rd_ptr;
    logic [15:0]    seq;
    entry_t         ent;
    trace_rec_t     rec;
    logic           full;
    logic           push;
    logic           pop;

    ////////////////////////////////////////////////////////////
    // tag table
    ////////////////////////////////////////////////////////////

    // live tags are distinct, so no two events hit one entry
    always_ff @(posedge clk) begin
        if (fetch_ev.valid) begin
            rec_table[fetch_ev.tag].pc   <= fetch_ev.pc;
            rec_table[fetch_ev.tag].word <= fetch_ev.word;
        end
        if (exec_ev.valid) begin
            rec_table[exec_ev.tag].result <= exec_ev.result;
        end
        if (mem_ev.valid) begin
            rec_table[mem_ev.tag].is_store <= mem_ev.is_store;
            rec_table[mem_ev.tag].addr     <= mem_ev.addr;
            rec_table[mem_ev.tag].sdata    <= mem_ev.sdata;
        end
    end

    // record assembly at write-back
    assign ent = rec_table[wb_ev.tag];

    always_comb begin
        rec.seq      = seq;
        rec.pc       = ent.pc;
        rec.word     = ent.word;
        rec.result   = ent.result;
        rec.is_store = ent.is_store;
        rec.addr     = ent.addr;
        rec.we       = wb_ev.we;
        rec.rd       = wb_ev.rd;
        // a store writes no register, its data word goes here instead
        rec.wdata    = ent.is_store ? ent.sdata : wb_ev.wdata;
    end

    ////////////////////////////////////////////////////////////
    // output queue
    ////////////////////////////////////////////////////////////

    assign push        = wb_ev.valid;
    assign pop         = trace_valid && trace_ready;
    assign trace_valid = wr_ptr != rd_ptr;
    assign full        = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                         (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);
    // no slot for a retiring record unless one leaves this cycle
    assign freeze      = full && !pop;
    assign trace       = queue[rd_ptr[ptr_w-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr[ptr_w-1:0]] <= rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            seq    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
                seq    <= seq + 16'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* source/traced_cpu_top.sv */
// traced cpu top level
// pipeline core plus retirement trace unit

module traced_cpu_top #(
    parameter int trace_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [15:0]           instr,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    output trace_pkg::trace_rec_t trace,
    output logic                  trace_valid,
    input  logic                  trace_ready
);

    import trace_pkg::*;

    // per-stage events, core to trace unit
    fetch_event_t fetch_ev;
    exec_event_t  exec_ev;
    mem_event_t   mem_ev;
    wb_event_t    wb_ev;
    // back-pressure from a full trace queue
    logic         freeze;

    pipe_core u_core (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .freeze      (freeze),
        .fetch_ev    (fetch_ev),
        .exec_ev     (exec_ev),
        .mem_ev      (mem_ev),
        .wb_ev       (wb_ev)
    );

    trace_unit #(
        .trace_depth (trace_depth)
    ) u_trace (
        .clk         (clk),
        .rst         (rst),
        .fetch_ev    (fetch_ev),
        .exec_ev     (exec_ev),
        .mem_ev      (mem_ev),
        .wb_ev       (wb_ev),
        .freeze      (freeze),
        .trace       (trace),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready)
    );

endmodule

/* tb/tb_traced_cpu.sv */
// testbench for the traced cpu
// streams the program from the vectors file and checks every retired trace record

module tb_traced_cpu;

    import trace_pkg::*;

    // cycles with trace_ready held low at the start of the first block
    localparam int hold_cycles = 40;

    logic        clk;
    logic        rst;
    logic [15:0] instr;
    logic        instr_valid;
    logic        instr_ready;
    trace_rec_t  trace;
    logic        trace_valid;
    logic        trace_ready;

    logic [15:0] prog_q [$];
    trace_rec_t  exp_q [$];
    int          prog_split = 0;
    int          rec_split = 0;
    int          check_errors = 0;
    int          other_errors = 0;
    int          got_total = 0;
    int          cycles = 0;
    int          cycle_limit = 100;
    integer      seed;

    traced_cpu_top #(
        .trace_depth (4)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .trace       (trace),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready)
    );

    always #4 clk = ~clk;

    // watchdog with a limit set from the number of expected records
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d expected records never arrived",
                     cycles, exp_q.size() - got_total, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // vectors file
    ////////////////////////////////////////////////////////////

    // I lines are program words, R lines records, S splits the blocks
    task automatic load_vectors;
        integer      fd;
        integer      c;
        integer      code;
        logic [15:0] word;
        logic [15:0] fld [9];
        trace_rec_t  rec;
        fd = $fopen("tb/trace_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open the vectors file tb/trace_vectors.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "I") begin
                    code = $fscanf(fd, " %h", word);
                    if (code != 1) begin
                        other_errors++;
                        $display("a program line in the vectors file could not be read");
                    end
                    prog_q.push_back(word);
                end else if (c == "R") begin
                    code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h", fld[0], fld[1],
                                   fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
                    if (code != 9) begin
                        other_errors++;
                        $display("a record line in the vectors file could not be read");
                    end
                    rec.seq      = fld[0];
                    rec.pc       = fld[1][7:0];
                    rec.word     = fld[2];
                    rec.result   = fld[3];
                    rec.is_store = fld[4][0];
                    rec.addr     = fld[5][3:0];
                    rec.we       = fld[6][0];
                    rec.rd       = fld[7][2:0];
                    rec.wdata    = fld[8];
                    exp_q.push_back(rec);
                end else if (c == "S") begin
                    prog_split = prog_q.size();
                    rec_split  = exp_q.size();
                end else if (c == "#") begin
                    // comment runs to end of line
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("no expected records were found in the vectors file");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_record(input trace_rec_t got, input trace_rec_t exp);
        check_field("trace.seq", exp.seq, got.seq);
        check_field("trace.pc", exp.pc, got.pc);
        check_field("trace.word", exp.word, got.word);
        check_field("trace.result", exp.result, got.result);
        check_field("trace.is_store", exp.is_store, got.is_store);
        check_field("trace.addr", exp.addr, got.addr);
        check_field("trace.we", exp.we, got.we);
        check_field("trace.rd", exp.rd, got.rd);
        check_field("trace.wdata", exp.wdata, got.wdata);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic apply_reset;
        rst         <= 1'b1;
        instr_valid <= 1'b0;
        trace_ready <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    // handshakes are sampled at the edge before the next drive
    task automatic run_block(input int p0, input int np, input int r0, input int nr,
                             input bit hold, input int gap_from);
        int         pi;
        int         ri;
        int         n;
        bit         waiting;
        trace_rec_t held;
        pi      = 0;
        ri      = 0;
        n       = 0;
        waiting = 1'b0;
        while (ri < nr) begin
            @(posedge clk);
            if (instr_valid && instr_ready) begin
                pi++;
            end
            // an offered record must stay put until taken
            if (waiting && (!trace_valid || trace !== held)) begin
                other_errors++;
                $display("trace record changed before it was taken at %0t", $time);
            end
            waiting = trace_valid && !trace_ready;
            held    = trace;
            if (trace_valid && trace_ready) begin
                compare_record(trace, exp_q[r0 + ri]);
                ri++;
                got_total++;
            end
            // queue is full by now so the core must refuse input
            if (hold && n == hold_cycles - 1 && (instr_ready || !trace_valid)) begin
                other_errors++;
                $display("instr_ready still high with a full trace queue at %0t", $time);
            end
            n++;
            if (pi < np) begin
                instr       <= prog_q[p0 + pi];
                instr_valid <= (pi < gap_from) || ($random(seed) % 4 != 0);
            end else begin
                instr_valid <= 1'b0;
            end
            trace_ready <= (hold && n < hold_cycles) ? 1'b0 : ($random(seed) % 3 != 0);
        end
        if (pi != np) begin
            other_errors++;
            $display("only %0d of %0d program words were accepted", pi, np);
        end
        // drain window for records that should not exist
        instr_valid <= 1'b0;
        trace_ready <= 1'b1;
        repeat (12) begin
            @(posedge clk);
            if (trace_valid && trace_ready) begin
                other_errors++;
                $display("extra trace record with seq %h at %0t", trace.seq, $time);
            end
        end
    endtask

    initial begin
        seed        = 32'hc147_00fc;
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = 16'h0000;
        instr_valid = 1'b0;
        trace_ready = 1'b0;
        load_vectors();
        cycle_limit = 40 * exp_q.size() + 100;
        apply_reset();
        // block 0 runs back-to-back up to word 6 and with gaps after it
        run_block(0, prog_split, 0, rec_split, 1'b1, 6);
        // second reset mid-program so state starts from zero again
        apply_reset();
        run_block(prog_split, prog_q.size() - prog_split, rec_split,
                  exp_q.size() - rec_split, 1'b0, 0);
        $display("records checked %0d, value mismatches %0d, other errors %0d",
                 got_total, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tb/trace_vectors.txt */
# I <word> : program word in acceptance order, hex
# R <seq> <pc> <word> <result> <is_store> <addr> <we> <rd> <wdata> : expected record, hex
# block 0: alu ops, forwarding, write to r0, store then load, load-use
I 6205
I 643d
I 1642
I 2843
I 5b02
I 4d41
I 3f41
I 1041
I 8e06
I 7206
I 1440
I 8a7f
R 0000 00 6205 0005 0 0 1 1 0005
R 0001 01 643d fffd 0 0 1 2 fffd
R 0002 02 1642 0002 0 0 1 3 0002
R 0003 03 2843 0003 0 0 1 4 0003
R 0004 04 5b02 fffe 0 0 1 5 fffe
R 0005 05 4d41 ffff 0 0 1 6 ffff
R 0006 06 3f41 0004 0 0 1 7 0004
R 0007 07 1041 000a 0 0 1 0 000a
R 0008 08 8e06 0006 1 6 0 7 0004
R 0009 09 7206 0006 0 6 1 1 0004
R 000a 0a 1440 0004 0 0 1 2 0004
R 000b 0b 8a7f 0003 1 3 0 5 fffe
# S: reset, then block 1 reads registers and memory that block 0 had set
S
I 7206
I 0000
I 1541
I 6781
I 79c3
R 0000 00 7206 0006 0 6 1 1 0000
R 0001 01 0000 0000 0 0 0 0 0000
R 0002 02 1541 0000 0 0 1 2 0000
R 0003 03 6781 0001 0 0 1 3 0001
R 0004 04 79c3 0003 0 3 1 4 0000

/* sources.f */
common/trace_pkg.sv
core/alu.sv
core/regfile.sv
core/hazard_unit.sv
core/pipe_core.sv
trace/trace_unit.sv
source/traced_cpu_top.sv
tb/tb_traced_cpu.sv

/* Bender.yml */
package:
  name: traced_cpu

sources:
  - files:
      - common/trace_pkg.sv
      - core/alu.sv
      - core/regfile.sv
      - core/hazard_unit.sv
      - core/pipe_core.sv
      - trace/trace_unit.sv
      - source/traced_cpu_top.sv
  - target: test
    files:
      - tb/tb_traced_cpu.sv
